//--- include/cpu_defines.svh
/*
 * Core parameters: data width, register file size,
 * reset address and program counter step
 */
`ifndef CPU_DEFINES_SVH
`define CPU_DEFINES_SVH

`define CPU_XLEN        32
`define CPU_REG_ADDR_W  5
`define CPU_REG_COUNT   32
`define CPU_RESET_PC    32'h0000_0000
`define CPU_INSTR_BYTES 4

`endif

//--- design/cpu_pkg.sv
/*
 * Shared types: major opcodes, ALU operations, instruction kinds,
 * the instruction word union and the decoded instruction struct
 */
`include "cpu_defines.svh"

package cpu_pkg;

    typedef enum logic [6:0] {
        OPC_LOAD   = 7'b0000011,
        OPC_STORE  = 7'b0100011,
        OPC_OP_IMM = 7'b0010011,
        OPC_OP     = 7'b0110011,
        OPC_BRANCH = 7'b1100011,
        OPC_LUI    = 7'b0110111,
        OPC_AUIPC  = 7'b0010111,
        OPC_JAL    = 7'b1101111,
        OPC_JALR   = 7'b1100111
    } opcode_e;

    typedef enum logic [3:0] {
        ALU_ADD, ALU_SUB, ALU_SLL, ALU_SLT, ALU_SLTU, ALU_XOR,
        ALU_SRL, ALU_SRA, ALU_OR, ALU_AND, ALU_PASS_B
    } alu_op_e;

    typedef enum logic [3:0] {
        KIND_ALU, KIND_LOAD, KIND_STORE, KIND_BRANCH, KIND_JAL,
        KIND_JALR, KIND_LUI, KIND_AUIPC, KIND_NOP
    } kind_e;

    typedef struct packed {
        logic [6:0]                 funct7;
        logic [`CPU_REG_ADDR_W-1:0] rs2;
        logic [`CPU_REG_ADDR_W-1:0] rs1;
        logic [2:0]                 funct3;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        opcode_e                    opcode;
    } r_view_t;

    typedef struct packed {
        logic [6:0]                 imm_hi; // imm[11:5]
        logic [`CPU_REG_ADDR_W-1:0] rs2;
        logic [`CPU_REG_ADDR_W-1:0] rs1;
        logic [2:0]                 funct3;
        logic [4:0]                 imm_lo; // imm[4:0]
        opcode_e                    opcode;
    } s_view_t;

    typedef union packed {
        r_view_t r;
        s_view_t s;
    } instr_t;

    typedef struct packed {
        kind_e                      kind;
        alu_op_e                    alu_op;
        logic                       use_imm;
        logic [2:0]                 funct3;  // Branch condition
        logic [`CPU_REG_ADDR_W-1:0] rs1;
        logic [`CPU_REG_ADDR_W-1:0] rs2;
        logic [`CPU_REG_ADDR_W-1:0] rd;
        logic [`CPU_XLEN-1:0]       imm;     // Sign-extended, U-type pre-shifted
    } decoded_t;

endpackage

//--- design/instr_decoder.sv
/*
 * Instruction decoder: opcode and function fields to operation kind,
 * ALU op, register indices and the format-specific immediate
 */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module instr_decoder
    import cpu_pkg::*;
(
    input  instr_t   instr,
    output decoded_t dec
);

    logic [`CPU_XLEN-1:0] imm_i;
    logic [`CPU_XLEN-1:0] imm_s;
    logic [`CPU_XLEN-1:0] imm_b;
    logic [`CPU_XLEN-1:0] imm_u;
    logic [`CPU_XLEN-1:0] imm_j;
    logic                 alt;
    logic                 ok_f7;

    function automatic alu_op_e arith_op(input logic [2:0] f3, input logic sub, input logic sra);
        case (f3)
            3'b000:  return sub ? ALU_SUB : ALU_ADD;
            3'b001:  return ALU_SLL;
            3'b010:  return ALU_SLT;
            3'b011:  return ALU_SLTU;
            3'b100:  return ALU_XOR;
            3'b101:  return sra ? ALU_SRA : ALU_SRL;
            3'b110:  return ALU_OR;
            default: return ALU_AND;
        endcase
    endfunction

    assign imm_i = {{20{instr.r.funct7[6]}}, instr.r.funct7, instr.r.rs2};
    assign imm_s = {{20{instr.s.imm_hi[6]}}, instr.s.imm_hi, instr.s.imm_lo};
    assign imm_b = {{20{instr.s.imm_hi[6]}}, instr.s.imm_lo[0], instr.s.imm_hi[5:0],
                    instr.s.imm_lo[4:1], 1'b0};
    assign imm_u = {instr.r.funct7, instr.r.rs2, instr.r.rs1, instr.r.funct3, 12'b0};
    assign imm_j = {{12{instr.r.funct7[6]}}, instr.r.rs1, instr.r.funct3, instr.r.rs2[0],
                    instr.r.funct7[5:0], instr.r.rs2[4:1], 1'b0};

    assign alt   = instr.r.funct7[5];  // SUB / SRA select
    assign ok_f7 = (instr.r.funct7 == 7'b0000000) ||
                   (instr.r.funct7 == 7'b0100000 &&
                    (instr.r.funct3 == 3'b000 || instr.r.funct3 == 3'b101));

    always_comb begin
        dec        = '0;
        dec.kind   = KIND_NOP;
        dec.funct3 = instr.r.funct3;
        dec.rs1    = instr.r.rs1;
        dec.rs2    = instr.r.rs2;
        dec.rd     = instr.r.rd;
        case (instr.r.opcode)
            OPC_OP: begin
                if (ok_f7) begin
                    dec.kind   = KIND_ALU;
                    dec.alu_op = arith_op(instr.r.funct3, alt, alt);
                end
            end
            OPC_OP_IMM: begin
                if (instr.r.funct3[1:0] != 2'b01 || ok_f7) begin  // Shifts check funct7
                    dec.kind    = KIND_ALU;
                    dec.use_imm = 1'b1;
                    dec.imm     = imm_i;
                    dec.alu_op  = arith_op(instr.r.funct3, 1'b0, alt);
                end
            end
            OPC_LOAD: begin
                if (instr.r.funct3 == 3'b010) begin  // LW only
                    dec.kind    = KIND_LOAD;
                    dec.use_imm = 1'b1;
                    dec.imm     = imm_i;
                end
            end
            OPC_STORE: begin
                if (instr.s.funct3 == 3'b010) begin  // SW only
                    dec.kind    = KIND_STORE;
                    dec.use_imm = 1'b1;
                    dec.imm     = imm_s;
                end
            end
            OPC_BRANCH: begin
                if (instr.r.funct3[2:1] != 2'b01) begin
                    dec.kind = KIND_BRANCH;
                    dec.imm  = imm_b;
                end
            end
            OPC_LUI: begin
                dec.kind    = KIND_LUI;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
                dec.alu_op  = ALU_PASS_B;
            end
            OPC_AUIPC: begin
                dec.kind    = KIND_AUIPC;
                dec.use_imm = 1'b1;
                dec.imm     = imm_u;
            end
            OPC_JAL: begin
                dec.kind    = KIND_JAL;
                dec.use_imm = 1'b1;
                dec.imm     = imm_j;
            end
            OPC_JALR: begin
                if (instr.r.funct3 == 3'b000) begin
                    dec.kind    = KIND_JALR;
                    dec.use_imm = 1'b1;
                    dec.imm     = imm_i;
                end
            end
            default: ;  // Unknown opcode stays a no-op
        endcase
    end

endmodule

//--- design/register_file.sv
/*
 * Register file: 32 entries, two combinational read ports,
 * one write port, x0 reads zero
 */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module register_file (
    input  logic                       clk,
    input  logic                       reset,
    input  logic [`CPU_REG_ADDR_W-1:0] raddr1,
    input  logic [`CPU_REG_ADDR_W-1:0] raddr2,
    output logic [`CPU_XLEN-1:0]       rdata1,
    output logic [`CPU_XLEN-1:0]       rdata2,
    input  logic                       we,
    input  logic [`CPU_REG_ADDR_W-1:0] waddr,
    input  logic [`CPU_XLEN-1:0]       wdata
);

    logic [`CPU_XLEN-1:0] regs [`CPU_REG_COUNT];

    always_ff @(posedge clk) begin
        if (reset) begin
            for (int i = 0; i < `CPU_REG_COUNT; i++) begin
                regs[i] <= '0;
            end
        end else if (we && waddr != '0) begin  // Writes to x0 dropped
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

//--- design/alu.sv
/*
 * ALU: add/sub, logic, shifts, set-less-than and operand pass,
 * plus the six branch comparisons selected by funct3
 */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module alu
    import cpu_pkg::*;
(
    input  alu_op_e              op,
    input  logic [2:0]           funct3,
    input  logic [`CPU_XLEN-1:0] a,
    input  logic [`CPU_XLEN-1:0] b,
    output logic [`CPU_XLEN-1:0] result,
    output logic                 taken
);

    logic [4:0] shamt;
    logic       lt_signed;
    logic       lt_unsigned;

    assign shamt       = b[4:0];
    assign lt_signed   = $signed(a) < $signed(b);
    assign lt_unsigned = a < b;

    always_comb begin
        case (op)
            ALU_SUB:    result = a - b;
            ALU_SLL:    result = a << shamt;
            ALU_SLT:    result = {{(`CPU_XLEN-1){1'b0}}, lt_signed};
            ALU_SLTU:   result = {{(`CPU_XLEN-1){1'b0}}, lt_unsigned};
            ALU_XOR:    result = a ^ b;
            ALU_SRL:    result = a >> shamt;
            ALU_SRA:    result = $signed(a) >>> shamt;
            ALU_OR:     result = a | b;
            ALU_AND:    result = a & b;
            ALU_PASS_B: result = b;
            default:    result = a + b;  // ALU_ADD
        endcase
    end

    always_comb begin
        case (funct3)
            3'b000:  taken = (a == b);     // BEQ
            3'b001:  taken = (a != b);     // BNE
            3'b100:  taken = lt_signed;    // BLT
            3'b101:  taken = !lt_signed;   // BGE
            3'b110:  taken = lt_unsigned;  // BLTU
            3'b111:  taken = !lt_unsigned; // BGEU
            default: taken = 1'b0;
        endcase
    end

endmodule

//--- design/cpu_control.sv
/*
 * Four-phase sequencer for decode, execute, memory and writeback.
 * Holds the PC and decoded instruction, drives ALU operands,
 * data memory strobes, register writeback and next-PC selection
 */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_control
    import cpu_pkg::*;
(
    input  logic                       clk,
    input  logic                       reset,
    input  decoded_t                   dec,
    input  logic [`CPU_XLEN-1:0]       rdata1,
    input  logic [`CPU_XLEN-1:0]       rdata2,
    input  logic [`CPU_XLEN-1:0]       alu_result,
    input  logic                       taken,
    input  logic [`CPU_XLEN-1:0]       drdata,
    output alu_op_e                    alu_op,
    output logic [2:0]                 alu_funct3,
    output logic [`CPU_XLEN-1:0]       alu_a,
    output logic [`CPU_XLEN-1:0]       alu_b,
    output logic [`CPU_REG_ADDR_W-1:0] rs1,
    output logic [`CPU_REG_ADDR_W-1:0] rs2,
    output logic                       rf_we,
    output logic [`CPU_REG_ADDR_W-1:0] rf_waddr,
    output logic [`CPU_XLEN-1:0]       rf_wdata,
    output logic [`CPU_XLEN-1:0]       iaddr,
    output logic [`CPU_XLEN-1:0]       daddr,
    output logic [`CPU_XLEN-1:0]       dwdata,
    output logic [3:0]                 dwe
);

    typedef enum logic [1:0] {PH_DECODE, PH_EXECUTE, PH_MEMORY, PH_WRITEBACK} phase_e;

    phase_e               phase;
    decoded_t             dec_q;
    logic [`CPU_XLEN-1:0] load_q;
    logic [`CPU_XLEN-1:0] pc_plus4;
    logic [`CPU_XLEN-1:0] next_pc;

    always_ff @(posedge clk) begin
        if (reset) begin
            phase <= PH_DECODE;
            iaddr <= `CPU_RESET_PC;
            dwe   <= '0;
        end else begin
            case (phase)
                PH_DECODE: phase <= PH_EXECUTE;
                PH_EXECUTE: begin
                    phase <= PH_MEMORY;
                    if (dec_q.kind == KIND_STORE) begin
                        dwe <= '1;  // Full word store
                    end
                end
                PH_MEMORY: begin
                    phase <= PH_WRITEBACK;
                    dwe   <= '0;
                end
                default: begin
                    phase <= PH_DECODE;
                    iaddr <= next_pc;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        case (phase)
            PH_DECODE: dec_q <= dec;
            PH_EXECUTE: begin
                if (dec_q.kind == KIND_LOAD || dec_q.kind == KIND_STORE) begin
                    daddr <= alu_result;
                end
                if (dec_q.kind == KIND_STORE) begin
                    dwdata <= rdata2;
                end
            end
            PH_MEMORY: begin
                if (dec_q.kind == KIND_LOAD) begin
                    load_q <= drdata;
                end
            end
            default: ;
        endcase
    end

    assign rs1        = dec_q.rs1;
    assign rs2        = dec_q.rs2;
    assign alu_op     = dec_q.alu_op;
    assign alu_funct3 = dec_q.funct3;
    assign alu_a      = (dec_q.kind == KIND_JAL || dec_q.kind == KIND_AUIPC) ? iaddr : rdata1;
    assign alu_b      = dec_q.use_imm ? dec_q.imm : rdata2;
    assign pc_plus4   = iaddr + `CPU_INSTR_BYTES;

    assign rf_waddr = dec_q.rd;
    assign rf_we    = (phase == PH_WRITEBACK) &&
                      (dec_q.kind inside {KIND_ALU, KIND_LOAD, KIND_JAL, KIND_JALR,
                                          KIND_LUI, KIND_AUIPC});

    always_comb begin
        case (dec_q.kind)
            KIND_LOAD:           rf_wdata = load_q;
            KIND_JAL, KIND_JALR: rf_wdata = pc_plus4;  // Link address
            default:             rf_wdata = alu_result;  // LUI immediate via ALU pass
        endcase
    end

    always_comb begin
        case (dec_q.kind)
            KIND_BRANCH: next_pc = taken ? iaddr + dec_q.imm : pc_plus4;
            KIND_JAL:    next_pc = alu_result;  // PC + imm from ALU
            KIND_JALR:   next_pc = {alu_result[`CPU_XLEN-1:1], 1'b0};
            default:     next_pc = pc_plus4;
        endcase
    end

endmodule

//--- design/cpu.sv
/*
 * Multi-cycle RV32I subset core: decoder, register file,
 * ALU and phase control
 */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu
    import cpu_pkg::*;
(
    input  logic                 clk,
    input  logic                 reset,
    output logic [`CPU_XLEN-1:0] iaddr,
    input  logic [`CPU_XLEN-1:0] idata,
    output logic [`CPU_XLEN-1:0] daddr,
    input  logic [`CPU_XLEN-1:0] drdata,
    output logic [`CPU_XLEN-1:0] dwdata,
    output logic [3:0]           dwe
);

    decoded_t                   dec;
    logic [`CPU_REG_ADDR_W-1:0] rs1;
    logic [`CPU_REG_ADDR_W-1:0] rs2;
    logic [`CPU_XLEN-1:0]       rdata1;
    logic [`CPU_XLEN-1:0]       rdata2;
    logic                       rf_we;
    logic [`CPU_REG_ADDR_W-1:0] rf_waddr;
    logic [`CPU_XLEN-1:0]       rf_wdata;
    alu_op_e                    alu_op;
    logic [2:0]                 alu_funct3;
    logic [`CPU_XLEN-1:0]       alu_a;
    logic [`CPU_XLEN-1:0]       alu_b;
    logic [`CPU_XLEN-1:0]       alu_result;
    logic                       taken;

    instr_decoder u_decoder (
        .instr (idata),
        .dec   (dec)
    );

    register_file u_regfile (
        .clk    (clk),
        .reset  (reset),
        .raddr1 (rs1),
        .raddr2 (rs2),
        .rdata1 (rdata1),
        .rdata2 (rdata2),
        .we     (rf_we),
        .waddr  (rf_waddr),
        .wdata  (rf_wdata)
    );

    alu u_alu (
        .op     (alu_op),
        .funct3 (alu_funct3),
        .a      (alu_a),
        .b      (alu_b),
        .result (alu_result),
        .taken  (taken)
    );

    cpu_control u_control (
        .clk        (clk),
        .reset      (reset),
        .dec        (dec),
        .rdata1     (rdata1),
        .rdata2     (rdata2),
        .alu_result (alu_result),
        .taken      (taken),
        .drdata     (drdata),
        .alu_op     (alu_op),
        .alu_funct3 (alu_funct3),
        .alu_a      (alu_a),
        .alu_b      (alu_b),
        .rs1        (rs1),
        .rs2        (rs2),
        .rf_we      (rf_we),
        .rf_waddr   (rf_waddr),
        .rf_wdata   (rf_wdata),
        .iaddr      (iaddr),
        .daddr      (daddr),
        .dwdata     (dwdata),
        .dwe        (dwe)
    );

endmodule

//--- verification/cpu_tb.sv
/*
 * Directed testbench for the multi-cycle core with instruction and data
 * memory models, a small program assembler, reference model and watchdog
 */
`timescale 1ns/1ps
`include "cpu_defines.svh"

module cpu_tb;

    localparam int CLK_PERIOD   = 4;
    localparam int RESET_CYCLES = 5;
    localparam int SEED         = 45677;
    localparam int INSTR_COUNT  = 160;  // Bound on instructions run over all tests
    localparam int RESET_COUNT  = 23;
    localparam int WATCHDOG_NS  =
        (INSTR_COUNT * 4 + RESET_COUNT * RESET_CYCLES + 100) * CLK_PERIOD;

    localparam int OP_LOAD  = 'h03;
    localparam int OP_IMM   = 'h13;
    localparam int OP_AUIPC = 'h17;
    localparam int OP_LUI   = 'h37;
    localparam int OP_JALR  = 'h67;

    // R-type order ADD SUB SLL SLT SLTU XOR SRL SRA OR AND
    localparam int R_F3  [10] = '{0, 0, 1, 2, 3, 4, 5, 5, 6, 7};
    localparam int R_ALT [10] = '{0, 1, 0, 0, 0, 0, 0, 1, 0, 0};
    // I-type order ADDI SLTI SLTIU XORI ORI ANDI SLLI SRLI SRAI
    localparam int I_F3  [9]  = '{0, 2, 3, 4, 6, 7, 1, 5, 5};
    localparam int I_ALT [9]  = '{0, 0, 0, 0, 0, 0, 0, 0, 1};

    logic                 clk = 1'b0;
    logic                 reset = 1'b1;
    logic [`CPU_XLEN-1:0] iaddr;
    logic [`CPU_XLEN-1:0] idata;
    logic [`CPU_XLEN-1:0] daddr;
    logic [`CPU_XLEN-1:0] drdata;
    logic [`CPU_XLEN-1:0] dwdata;
    logic [3:0]           dwe;

    logic [31:0] imem [256];
    logic [31:0] dmem [1024];
    logic [31:0] prog [$];
    int          store_cycles = 0;

    cpu DUT (
        .clk    (clk),
        .reset  (reset),
        .iaddr  (iaddr),
        .idata  (idata),
        .daddr  (daddr),
        .drdata (drdata),
        .dwdata (dwdata),
        .dwe    (dwe)
    );

    assign idata  = imem[iaddr[9:2]];
    assign drdata = dmem[daddr[11:2]];  // Combinational read

    always #(CLK_PERIOD / 2) clk = ~clk;

    always @(posedge clk) begin
        if (!reset && dwe != 4'h0) begin
            compare("dwe", 32'(dwe), 32'hF);
            dmem[daddr[11:2]] = dwdata;
            store_cycles = store_cycles + 1;
        end
    end

    initial begin
        #(WATCHDOG_NS);
        $display("ERROR: watchdog expired after %0d ns, the tests did not finish", WATCHDOG_NS);
        stop_with_failure();
    end

    task automatic stop_with_failure();
        $display("Some tests failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic compare(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("MISMATCH at %0d ns: %s = %h, expected %h", $time, name, got, expected);
            stop_with_failure();
        end
    endtask

    task automatic check_mem(input logic [31:0] addr, input logic [31:0] expected);
        compare($sformatf("dmem[%h]", addr), dmem[addr[11:2]], expected);
    endtask

    function automatic logic [31:0] r_type(input logic [31:0] f7, rs2, rs1, f3, rd);
        return {f7[6:0], rs2[4:0], rs1[4:0], f3[2:0], rd[4:0], 7'h33};
    endfunction

    function automatic logic [31:0] i_type(input logic [31:0] imm, rs1, f3, rd, op);
        return {imm[11:0], rs1[4:0], f3[2:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] s_type(input logic [31:0] imm, rs2, rs1);
        return {imm[11:5], rs2[4:0], rs1[4:0], 3'b010, imm[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] b_type(input logic [31:0] imm, rs2, rs1, f3);
        return {imm[12], imm[10:5], rs2[4:0], rs1[4:0], f3[2:0], imm[4:1], imm[11], 7'h63};
    endfunction

    function automatic logic [31:0] u_type(input logic [31:0] imm, rd, op);
        return {imm[19:0], rd[4:0], op[6:0]};
    endfunction

    function automatic logic [31:0] j_type(input logic [31:0] imm, rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd[4:0], 7'h6F};
    endfunction

    // LUI then ADDI with the upper part rounded for the signed low part
    task automatic load_const(input int rd, input logic [31:0] value);
        prog.push_back(u_type((value + 32'h800) >> 12, rd, OP_LUI));
        prog.push_back(i_type(value & 32'hFFF, rd, 0, rd, OP_IMM));
    endtask

    function automatic logic [31:0] alu_expected(input int f3, input int alt,
                                                 input logic [31:0] a, b);
        case (f3)
            0:       return (alt != 0) ? a - b : a + b;
            1:       return a << b[4:0];
            2:       return ($signed(a) < $signed(b)) ? 1 : 0;
            3:       return (a < b) ? 1 : 0;
            4:       return a ^ b;
            5:       return (alt != 0) ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            6:       return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic bit branch_expected(input int f3, input logic [31:0] a, b);
        case (f3)
            0:       return a == b;
            1:       return a != b;
            4:       return $signed(a) < $signed(b);
            5:       return $signed(a) >= $signed(b);
            6:       return a < b;
            7:       return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    task automatic load_and_reset();
        for (int i = 0; i < 256; i++) begin
            imem[i[7:0]] = (i < prog.size()) ? prog[i] : 32'h0;  // Zero word is a no-op
        end
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
    endtask

    task automatic wait_for_iaddr(input logic [31:0] target, input int limit);
        int cycles;
        cycles = 0;
        while (iaddr !== target) begin
            if (cycles >= limit) begin
                $display("ERROR: iaddr did not reach %h within %0d cycles", target, limit);
                stop_with_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    task automatic wait_for_change(input logic [31:0] from, input int limit);
        int cycles;
        cycles = 0;
        while (iaddr === from) begin
            if (cycles >= limit) begin
                $display("ERROR: iaddr stuck at %h for %0d cycles", from, limit);
                stop_with_failure();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    // Runs until the fetch address passes the last instruction
    task automatic run_program(input int stores);
        int start;
        int n;
        n = prog.size();
        start = store_cycles;
        load_and_reset();
        wait_for_iaddr(n * `CPU_INSTR_BYTES, n * 4 + 8);
        compare("store cycles", store_cycles - start, stores);
    endtask

    task automatic test_reset_and_nops();
        prog.delete();
        load_and_reset();
        compare("iaddr", iaddr, `CPU_RESET_PC);
        compare("dwe", 32'(dwe), 0);
        for (int k = 1; k <= 16; k++) begin
            @(negedge clk);
            compare("iaddr", iaddr, (k / 4) * `CPU_INSTR_BYTES);
            compare("dwe", 32'(dwe), 0);
        end
    endtask

    task automatic test_alu_ops();
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] imm;
        logic [31:0] want [$];
        a = $urandom;
        b = $urandom;
        prog.delete();
        load_const(1, a);
        load_const(2, b);
        for (int i = 0; i < 10; i++) begin
            prog.push_back(r_type(R_ALT[i] * 'h20, 2, 1, R_F3[i], 3));
            prog.push_back(s_type('h100 + 4 * i, 3, 0));
            want.push_back(alu_expected(R_F3[i], R_ALT[i], a, b));
        end
        for (int i = 0; i < 9; i++) begin
            imm = $urandom & 32'hFFF;
            if (I_F3[i] == 1 || I_F3[i] == 5) begin
                imm = (imm & 32'h1F) | (I_ALT[i] * 32'h400);  // funct7 above shamt
            end
            prog.push_back(i_type(imm, 1, I_F3[i], 3, OP_IMM));
            prog.push_back(s_type('h100 + 4 * (10 + i), 3, 0));
            want.push_back(alu_expected(I_F3[i], I_ALT[i], a, {{20{imm[11]}}, imm[11:0]}));
        end
        run_program(19);
        for (int i = 0; i < 19; i++) begin
            check_mem('h100 + 4 * i, want[i]);
        end
    endtask

    task automatic test_load_store();
        logic [31:0] word;
        logic [31:0] addr;
        word = $urandom;
        addr = 'h200 + 4 * ($urandom % 64);
        prog.delete();
        load_const(5, word);
        load_const(7, addr);
        prog.push_back(s_type(0, 5, 7));
        prog.push_back(i_type(0, 7, 2, 6, OP_LOAD));
        prog.push_back(s_type('h7F0, 6, 0));
        run_program(2);
        check_mem(addr, word);
        check_mem('h7F0, word);
    endtask

    // Pairs (x,x), (x,y), (y,x) give both outcomes for every condition
    task automatic test_branches();
        logic [31:0] x;
        logic [31:0] y;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] target;
        int          f3;
        x = $urandom;
        y = $urandom;
        if (y == x) begin
            y = ~x;
        end
        for (int f = 0; f < 6; f++) begin
            f3 = (f < 2) ? f : f + 2;
            for (int p = 0; p < 3; p++) begin
                a = (p == 2) ? y : x;
                b = (p == 1) ? y : x;
                prog.delete();
                load_const(1, a);
                load_const(2, b);
                prog.push_back(b_type(12, 2, 1, f3));  // At 0x10
                repeat (3) prog.push_back(32'h0);
                load_and_reset();
                wait_for_iaddr(16, 24);
                wait_for_change(16, 8);
                target = branch_expected(f3, a, b) ? 16 + 12 : 16 + `CPU_INSTR_BYTES;
                compare($sformatf("iaddr after branch funct3=%0d", f3), iaddr, target);
            end
        end
    endtask

    task automatic test_jumps();
        logic [31:0] u;
        u = $urandom & 32'hFFFFF;
        prog.delete();
        prog.push_back(j_type(12, 1));                // 0x00 to 0x0C
        prog.push_back(i_type(1, 0, 0, 9, OP_IMM));   // Skipped
        prog.push_back(i_type(1, 0, 0, 9, OP_IMM));
        prog.push_back(s_type('h300, 1, 0));
        prog.push_back(i_type(25, 0, 0, 4, OP_IMM));
        prog.push_back(i_type(8, 4, 0, 5, OP_JALR));  // Target 25 + 8 with bit 0 cleared
        prog.push_back(i_type(1, 0, 0, 9, OP_IMM));
        prog.push_back(i_type(1, 0, 0, 9, OP_IMM));
        prog.push_back(s_type('h304, 5, 0));
        prog.push_back(u_type(u, 6, OP_AUIPC));       // At 0x24
        prog.push_back(s_type('h308, 6, 0));
        prog.push_back(s_type('h30C, 9, 0));
        run_program(4);
        check_mem('h300, 4);
        check_mem('h304, 24);
        check_mem('h308, 36 + (u << 12));
        check_mem('h30C, 0);
    endtask

    task automatic test_x0();
        logic [31:0] r1;
        logic [31:0] r2;
        r1 = ($urandom & 32'hFFF) | 1;
        r2 = ($urandom & 32'hFFFFF) | 1;
        prog.delete();
        prog.push_back(i_type(r1, 0, 0, 0, OP_IMM));
        prog.push_back(u_type(r2, 0, OP_LUI));
        prog.push_back(s_type('h310, 0, 0));
        run_program(1);
        check_mem('h310, 0);
    endtask

    initial begin
        void'($urandom(SEED));
        for (int i = 0; i < 1024; i++) begin
            dmem[i[9:0]] = {6'h2A, i[9:0], 6'h15, i[9:0]};
        end
        test_reset_and_nops();
        test_alu_ops();
        test_load_store();
        test_branches();
        test_jumps();
        test_x0();
        $display("All tests passed");
        $finish;
    end

endmodule

//--- project.f
+incdir+include
design/cpu_pkg.sv
design/instr_decoder.sv
design/register_file.sv
design/alu.sv
design/cpu_control.sv
design/cpu.sv
verification/cpu_tb.sv

//--- Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing
TOP       := cpu_tb
FILELIST  := project.f
BUILD_DIR := obj_dir
LOG       := sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the simulation and check $(LOG)"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"
	@echo "  help   list these targets"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@grep -q "All tests passed" $(LOG) || (echo "FAIL: see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
